// File: design/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define REG_COUNT     32
`define REG_IDX_BITS  5

// datapath width
`define DATA_BITS     32

// reorder buffer depth is a power of two so the pointers wrap on their own
`define ROB_DEPTH     8
`define ROB_TAG_BITS  3

`endif

// File: design/rename_pkg.sv
`include "rename_config.svh"

package rename_pkg;

    // register index
    typedef logic [`REG_IDX_BITS-1:0] reg_idx_t;

    // data word
    typedef logic [`DATA_BITS-1:0] data_t;

    // reorder buffer entry index doubling as the rename tag
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;

    // op_loadi passes the immediate and reads no sources
    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_xor   = 2'd2,
        op_loadi = 2'd3
    } alu_op_t;

endpackage : rename_pkg

// File: design/reg_status_file.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module reg_status_file import rename_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    // dispatch read ports
    input  reg_idx_t read1,
    input  reg_idx_t read2,
    output data_t    value1,
    output data_t    value2,
    output logic     busy1,
    output logic     busy2,
    output rob_tag_t tag1,
    output rob_tag_t tag2,
    // destination marked busy by dispatch
    input  logic     rename_valid,
    input  reg_idx_t rename_rd,
    input  rob_tag_t rename_tag,
    // in-order write from the reorder buffer
    input  logic     retire_valid,
    input  reg_idx_t retire_rd,
    input  rob_tag_t retire_tag,
    input  data_t    retire_value
);

    data_t    value_q [`REG_COUNT];
    logic     busy_q  [`REG_COUNT];
    rob_tag_t tag_q   [`REG_COUNT];

    generate
        for (genvar regi = 0; regi < `REG_COUNT; regi++) begin : g_reg
            if (regi == 0) begin : g_zero
                // register 0 is hardwired
                always_ff @(posedge clk) begin
                    value_q[regi] <= '0;
                    busy_q[regi]  <= 1'b0;
                    tag_q[regi]   <= '0;
                end
            end else begin : g_arch
                always_ff @(posedge clk) begin
                    if (rst) begin
                        value_q[regi] <= '0;
                        busy_q[regi]  <= 1'b0;
                        tag_q[regi]   <= '0;
                    end else begin
                        if (retire_valid && retire_rd == regi) begin
                            value_q[regi] <= retire_value;
                            // only the newest producer frees the register
                            if (retire_tag == tag_q[regi]) begin
                                busy_q[regi] <= 1'b0;
                                tag_q[regi]  <= '0;
                            end
                        end
                        if (flush) begin
                            busy_q[regi] <= 1'b0;
                            tag_q[regi]  <= '0;
                        end else if (rename_valid && rename_rd == regi) begin
                            // same-cycle rename overrides the retire clear
                            busy_q[regi] <= 1'b1;
                            tag_q[regi]  <= rename_tag;
                        end
                    end
                end
            end
        end
    endgenerate

    assign value1 = value_q[read1];
    assign value2 = value_q[read2];
    assign busy1  = busy_q[read1];
    assign busy2  = busy_q[read2];
    assign tag1   = tag_q[read1];
    assign tag2   = tag_q[read2];

endmodule : reg_status_file

// File: design/reorder_buffer.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    // allocation from dispatch
    input  logic     alloc_valid,
    input  reg_idx_t alloc_rd,
    output rob_tag_t alloc_tag,
    output logic     full,
    output logic     empty,
    // operand forwarding for busy sources
    input  rob_tag_t query_tag1,
    input  rob_tag_t query_tag2,
    output logic     query_ready1,
    output logic     query_ready2,
    output data_t    query_value1,
    output data_t    query_value2,
    // result from the ALU
    input  logic     wb_valid,
    input  rob_tag_t wb_tag,
    input  data_t    wb_value,
    // in-order retirement into the register status file
    output logic     retire_valid,
    output reg_idx_t retire_rd,
    output rob_tag_t retire_tag,
    output data_t    retire_value,
    // registered commit report
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output data_t    commit_value
);

    reg_idx_t rd_q    [`ROB_DEPTH];
    data_t    value_q [`ROB_DEPTH];
    logic     ready_q [`ROB_DEPTH];

    rob_tag_t                head_q;
    rob_tag_t                tail_q;
    logic [`ROB_TAG_BITS:0]  count_q;

    logic alloc_fire;
    logic wb_fire;

    assign full  = (count_q == `ROB_DEPTH);
    assign empty = (count_q == '0);

    assign alloc_tag  = tail_q;
    assign alloc_fire = alloc_valid && !flush;
    // late result during a flush belongs to discarded work
    assign wb_fire    = wb_valid && !flush;

    assign query_ready1 = ready_q[query_tag1];
    assign query_ready2 = ready_q[query_tag2];
    assign query_value1 = value_q[query_tag1];
    assign query_value2 = value_q[query_tag2];

    // head leaves as soon as its result is in
    assign retire_valid = !empty && ready_q[head_q];
    assign retire_rd    = rd_q[head_q];
    assign retire_tag   = head_q;
    assign retire_value = value_q[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                ready_q[i] <= 1'b0;
            end
        end else begin
            // an entry retiring on the flush edge is still reported
            commit_valid <= retire_valid;
            if (flush) begin
                head_q  <= '0;
                tail_q  <= '0;
                count_q <= '0;
            end else begin
                if (alloc_fire) begin
                    tail_q <= tail_q + 1'b1;
                end
                if (retire_valid) begin
                    head_q <= head_q + 1'b1;
                end
                case ({alloc_fire, retire_valid})
                    2'b10:   count_q <= count_q + 1'b1;
                    2'b01:   count_q <= count_q - 1'b1;
                    default: count_q <= count_q;
                endcase
            end
            if (alloc_fire) begin
                ready_q[tail_q] <= 1'b0;
            end
            if (wb_fire) begin
                ready_q[wb_tag] <= 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (wb_fire) begin
            value_q[wb_tag] <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        commit_rd    <= retire_rd;
        commit_value <= retire_value;
    end

endmodule : reorder_buffer

// File: design/dispatch_unit.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module dispatch_unit import rename_pkg::*; (
    // instruction stream in program order
    input  logic     in_valid,
    output logic     in_ready,
    input  alu_op_t  in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  data_t    in_imm,
    input  logic     flush,
    input  logic     rob_full,
    // register status file lookup
    output reg_idx_t read1,
    output reg_idx_t read2,
    input  data_t    value1,
    input  data_t    value2,
    input  logic     busy1,
    input  logic     busy2,
    input  rob_tag_t tag1,
    input  rob_tag_t tag2,
    // reorder buffer forwarding
    output rob_tag_t query_tag1,
    output rob_tag_t query_tag2,
    input  logic     query_ready1,
    input  logic     query_ready2,
    input  data_t    query_value1,
    input  data_t    query_value2,
    // allocation and rename
    output logic     alloc_valid,
    output reg_idx_t alloc_rd,
    input  rob_tag_t alloc_tag,
    output logic     rename_valid,
    output reg_idx_t rename_rd,
    output rob_tag_t rename_tag,
    // issue into the ALU
    output logic     issue_valid,
    output alu_op_t  issue_op,
    output data_t    issue_a,
    output data_t    issue_b,
    output rob_tag_t issue_tag
);

    logic is_loadi;
    logic src1_ok;
    logic src2_ok;
    logic accept;

    assign read1      = in_rs1;
    assign read2      = in_rs2;
    assign query_tag1 = tag1;
    assign query_tag2 = tag2;

    assign is_loadi = (in_op == op_loadi);

    // a busy source waits until its producer has a result
    assign src1_ok = is_loadi || !busy1 || query_ready1;
    assign src2_ok = is_loadi || !busy2 || query_ready2;

    assign in_ready = !flush && !rob_full && src1_ok && src2_ok;
    assign accept   = in_valid && in_ready;

    assign alloc_valid = accept;
    assign alloc_rd    = in_rd;

    // register 0 never goes busy
    assign rename_valid = accept && (in_rd != '0);
    assign rename_rd    = in_rd;
    assign rename_tag   = alloc_tag;

    assign issue_valid = accept;
    assign issue_op    = in_op;
    assign issue_tag   = alloc_tag;
    assign issue_a     = busy1 ? query_value1 : value1;
    assign issue_b     = is_loadi ? in_imm : (busy2 ? query_value2 : value2);

endmodule : dispatch_unit

// File: design/exec_alu.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module exec_alu import rename_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     issue_valid,
    input  alu_op_t  issue_op,
    input  data_t    issue_a,
    input  data_t    issue_b,
    input  rob_tag_t issue_tag,
    output logic     wb_valid,
    output rob_tag_t wb_tag,
    output data_t    wb_value
);

    logic     s1_valid;
    alu_op_t  s1_op;
    data_t    s1_a;
    data_t    s1_b;
    rob_tag_t s1_tag;
    data_t    result;

    always_comb begin
        case (s1_op)
            op_add:  result = s1_a + s1_b;
            op_sub:  result = s1_a - s1_b;
            op_xor:  result = s1_a ^ s1_b;
            // immediate arrives on operand b
            default: result = s1_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid;
            wb_valid <= s1_valid;
        end
    end

    // stage payload
    always_ff @(posedge clk) begin
        s1_op    <= issue_op;
        s1_a     <= issue_a;
        s1_b     <= issue_b;
        s1_tag   <= issue_tag;
        wb_tag   <= s1_tag;
        wb_value <= result;
    end

endmodule : exec_alu

// File: design/rename_core.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module rename_core import rename_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  alu_op_t  in_op,
    input  reg_idx_t in_rd,
    input  reg_idx_t in_rs1,
    input  reg_idx_t in_rs2,
    input  data_t    in_imm,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output data_t    commit_value,
    output logic     idle
);

    // register status file lookup
    reg_idx_t read1, read2;
    data_t    value1, value2;
    logic     busy1, busy2;
    rob_tag_t tag1, tag2;

    // forwarding queries
    rob_tag_t query_tag1, query_tag2;
    logic     query_ready1, query_ready2;
    data_t    query_value1, query_value2;

    // allocation and rename
    logic     alloc_valid, rob_full;
    reg_idx_t alloc_rd;
    rob_tag_t alloc_tag;
    logic     rename_valid;
    reg_idx_t rename_rd;
    rob_tag_t rename_tag;

    // issue and write-back
    logic     issue_valid;
    alu_op_t  issue_op;
    data_t    issue_a, issue_b;
    rob_tag_t issue_tag;
    logic     wb_valid;
    rob_tag_t wb_tag;
    data_t    wb_value;

    // retirement
    logic     retire_valid;
    reg_idx_t retire_rd;
    rob_tag_t retire_tag;
    data_t    retire_value;

    dispatch_unit u_dispatch (
        .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2, .in_imm,
        .flush, .rob_full,
        .read1, .read2, .value1, .value2, .busy1, .busy2, .tag1, .tag2,
        .query_tag1, .query_tag2, .query_ready1, .query_ready2,
        .query_value1, .query_value2,
        .alloc_valid, .alloc_rd, .alloc_tag,
        .rename_valid, .rename_rd, .rename_tag,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag
    );

    reg_status_file u_rsf (
        .clk, .rst, .flush,
        .read1, .read2, .value1, .value2, .busy1, .busy2, .tag1, .tag2,
        .rename_valid, .rename_rd, .rename_tag,
        .retire_valid, .retire_rd, .retire_tag, .retire_value
    );

    // an empty reorder buffer implies an empty ALU
    reorder_buffer u_rob (
        .clk, .rst, .flush,
        .alloc_valid, .alloc_rd, .alloc_tag, .full(rob_full), .empty(idle),
        .query_tag1, .query_tag2, .query_ready1, .query_ready2,
        .query_value1, .query_value2,
        .wb_valid, .wb_tag, .wb_value,
        .retire_valid, .retire_rd, .retire_tag, .retire_value,
        .commit_valid, .commit_rd, .commit_value
    );

    exec_alu u_alu (
        .clk, .rst, .flush,
        .issue_valid, .issue_op, .issue_a, .issue_b, .issue_tag,
        .wb_valid, .wb_tag, .wb_value
    );

endmodule : rename_core

// File: dv/rename_core_tb.sv
`timescale 1ns/10ps
`include "rename_config.svh"

module rename_core_tb import rename_pkg::*; ();

    localparam int max_cases = 256;

    logic     clk = 1'b0;
    logic     rst;
    logic     flush;
    logic     in_valid;
    logic     in_ready;
    alu_op_t  in_op;
    reg_idx_t in_rd;
    reg_idx_t in_rs1;
    reg_idx_t in_rs2;
    data_t    in_imm;
    logic     commit_valid;
    reg_idx_t commit_rd;
    data_t    commit_value;
    logic     idle;

    // one entry per non-comment line of the cases file
    string    c_kind [max_cases];
    int       c_op   [max_cases];
    reg_idx_t c_rd   [max_cases];
    reg_idx_t c_rs1  [max_cases];
    reg_idx_t c_rs2  [max_cases];
    data_t    c_imm  [max_cases];
    data_t    c_exp  [max_cases];
    int       n_cases;

    data_t arch [`REG_COUNT];
    int    in_flight [$];
    int    cur;
    logic  flush_seen = 1'b0;
    int    seed = 32'heedc;
    int    cycles = 0;
    int    cycle_limit = 0;
    int    errors = 0;
    int    test_errors = 0;
    int    commits = 0;
    int    test_commits = 0;
    int    flushed = 0;
    int    test_num = 0;

    rename_core uut (
        .clk, .rst, .flush, .in_valid, .in_ready, .in_op, .in_rd, .in_rs1, .in_rs2,
        .in_imm, .commit_valid, .commit_rd, .commit_value, .idle
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic record_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    // result of one instruction executed in program order
    function automatic data_t sequential_result(int op, data_t a, data_t b, data_t imm);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a ^ b;
            default: return imm;
        endcase
    endfunction

    // check the commit, then drop flushed work, then record an accept
    always @(negedge clk) begin : monitor
        int    idx;
        data_t expected;
        if (!rst && commit_valid) begin
            commits++;
            test_commits++;
            assert (in_flight.size() > 0)
                else record_error("commit reported with no instruction outstanding");
            if (in_flight.size() > 0) begin
                idx = in_flight.pop_front();
                expected = sequential_result(c_op[idx], arch[c_rs1[idx]], arch[c_rs2[idx]],
                                             c_imm[idx]);
                assert (commit_rd == c_rd[idx]) else record_error(
                    $sformatf("Error commit_rd expected %h got %h", c_rd[idx], commit_rd));
                assert (commit_value == expected) else record_error(
                    $sformatf("Error commit_value expected %h got %h", expected, commit_value));
                if (c_kind[idx] == "I") begin
                    assert (commit_value == c_exp[idx]) else record_error($sformatf(
                        "Error commit_value expected %h got %h", c_exp[idx], commit_value));
                end
                if (c_rd[idx] != '0) begin
                    arch[c_rd[idx]] = expected;
                end
            end
        end
        // everything still outstanding after the flush edge is gone
        if (flush_seen) begin
            flushed += in_flight.size();
            in_flight.delete();
            flush_seen = 1'b0;
        end
        if (flush) begin
            flush_seen = 1'b1;
        end
        if (in_valid && in_ready) begin
            in_flight.push_back(cur);
        end
    end

    task automatic send_instruction(input int idx);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(posedge clk);
            #5;
        end
        in_op    = alu_op_t'(c_op[idx]);
        in_rd    = c_rd[idx];
        in_rs1   = c_rs1[idx];
        in_rs2   = c_rs2[idx];
        in_imm   = c_imm[idx];
        cur      = idx;
        in_valid = 1'b1;
        do @(negedge clk); while (!in_ready);
        @(posedge clk);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic pulse_flush(input int wait_cycles);
        repeat (wait_cycles) begin
            @(posedge clk);
            #5;
        end
        flush = 1'b1;
        @(posedge clk);
        #5;
        flush = 1'b0;
    endtask

    task automatic finish_test();
        do @(negedge clk); while (!idle);
        // let the last commit be checked
        @(negedge clk);
        assert (in_flight.size() == 0)
            else record_error("instructions were dispatched but never committed");
        test_num++;
        $display("test %0d: %0d commits, %0d errors", test_num, test_commits, test_errors);
        test_commits = 0;
        test_errors = 0;
        @(posedge clk);
        #5;
    endtask

    initial begin
        int    fd;
        string line;
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_op    = op_add;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        cur      = 0;
        n_cases  = 0;
        foreach (arch[r]) begin
            arch[r] = '0;
        end
        fd = $fopen("dv/rename_cases.txt", "r");
        if (fd == 0) begin
            record_error("cannot open the cases file dv/rename_cases.txt");
        end
        while (fd != 0 && $fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                void'($sscanf(line, "%s %d %d %d %d %h %h", c_kind[n_cases], c_op[n_cases],
                    c_rd[n_cases], c_rs1[n_cases], c_rs2[n_cases], c_imm[n_cases],
                    c_exp[n_cases]));
                n_cases++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = 20 * n_cases + 200;

        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        assert (idle && !commit_valid && in_ready)
            else record_error("core is not idle and ready after reset");

        for (int i = 0; i < n_cases; i++) begin
            if (c_kind[i] == "I" || c_kind[i] == "U") begin
                send_instruction(i);
            end else if (c_kind[i] == "F") begin
                pulse_flush(c_op[i]);
            end else if (c_kind[i] == "W") begin
                finish_test();
            end else begin
                record_error($sformatf("unknown line kind %s in the cases file", c_kind[i]));
            end
        end

        $display("commits %0d, flushed %0d, errors %0d", commits, flushed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : rename_core_tb

// File: dv/rename_cases.txt
# I op rd rs1 rs2 imm expected, U op rd rs1 rs2 imm (value checked against commits only)
# F cycles pulses flush, W waits for idle and ends a test; op 0 add 1 sub 2 xor 3 loadi
I 3 1 0 0 0000000a 0000000a
I 3 2 0 0 00000014 00000014
I 3 3 0 0 00000005 00000005
I 3 4 0 0 ffffffff ffffffff
W
I 0 5 1 2 0 0000001e
I 0 5 5 3 0 00000023
I 1 6 5 1 0 00000019
I 2 7 6 4 0 ffffffe6
I 0 5 5 5 0 00000046
W
I 3 0 0 0 00000077 00000077
I 0 9 0 1 0 0000000a
I 1 10 0 2 0 ffffffec
W
I 3 11 0 0 00000001 00000001
I 3 12 0 0 00000002 00000002
I 0 13 11 12 0 00000003
I 0 14 13 13 0 00000006
I 0 15 14 11 0 00000007
I 2 16 15 12 0 00000005
I 1 17 16 14 0 ffffffff
I 0 18 17 11 0 00000000
I 3 19 0 0 00000100 00000100
I 0 20 19 19 0 00000200
W
U 3 21 0 0 00000033
U 0 22 21 1 0
U 0 1 22 22 0
F 1
U 0 23 1 0 0
I 0 24 2 3 0 00000019
W

// File: filelist.f
+incdir+design
design/rename_pkg.sv
design/reg_status_file.sv
design/reorder_buffer.sv
design/dispatch_unit.sv
design/exec_alu.sv
design/rename_core.sv
dv/rename_core_tb.sv
